// File: build.f
+incdir+logic
+incdir+tests
logic/ctrl_pkg.sv
logic/ctrl_ifs.sv
logic/aer_event_decode.sv
logic/event_fsm.sv
logic/mem_access_gen.sv
logic/event_ctrl_top.sv
tests/event_ctrl_tb.sv

// File: logic/aer_event_decode.sv
//----------------------------------------------------------------------
// AER input stage
// Brings the request into the clock domain and classifies the address,
// which the sender holds stable for the whole handshake
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defines.svh"

module aer_event_decode import ctrl_pkg::*; (
    input  wire logic      CLK,
    input  wire logic      RST,
    input  wire logic      aerin_req,
    input  wire aer_addr_t aerin_addr,
    aer_event_if.src       ev
);

    logic req_meta;
    logic req_sync;

    // ------------------------------------------------------------------
    // Two-flop synchronizer on the request
    // ------------------------------------------------------------------
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
        end else begin
            req_meta <= aerin_req;
            req_sync <= req_meta;
        end
    end

    assign ev.req    = req_sync;
    assign ev.addr   = aerin_addr;
    // Single-neuron select for tref events
    assign ev.single = aerin_addr[`CTRL_SINGLE_BIT];

    // ------------------------------------------------------------------
    // Event classification
    // ------------------------------------------------------------------
    always_comb begin
        if (aerin_addr[`CTRL_SYN_FLAG]) begin
            ev.kind = EV_SYNAPSE;
        end else if (&aerin_addr[`CTRL_KIND_W-1:0]) begin
            ev.kind = EV_TREF;
        end else if (~|aerin_addr[`CTRL_KIND_W-1:0]) begin
            // Old self-test pattern, only acknowledged
            ev.kind = EV_IGNORE;
        end else begin
            ev.kind = EV_PUSH;
        end
    end

endmodule

`default_nettype wire

// File: logic/ctrl_defines.svh
//----------------------------------------------------------------------
// Sizes and field positions of the event controller
// Included by the package and by every module that slices an address
//----------------------------------------------------------------------
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// Neuron address and AER address layout
`define CTRL_M            8
`define CTRL_AER_W        (2*`CTRL_M+1)
`define CTRL_SYN_FLAG     (2*`CTRL_M)
`define CTRL_SINGLE_BIT   (`CTRL_M-1)
`define CTRL_KIND_W       (`CTRL_M-1)
// Low address bits that pick the pre-enable bit
`define CTRL_PRE_SEL_W    3

// Memory and scheduler widths
`define CTRL_SYN_ADDR_W   13
`define CTRL_VIRTS_W      5
`define CTRL_SCHED_W      (`CTRL_M+`CTRL_VIRTS_W)
`define CTRL_EVENT_IN_W   7
`define CTRL_PUSH_CODE    7'h40
`define CTRL_TREF_BLOCK   32
`define CTRL_PRE_EN_W     8

`endif

// File: logic/ctrl_ifs.sv
//----------------------------------------------------------------------
// Level interfaces between the controller modules
// aer_event_if carries the decoded event, ctrl_step_if the FSM position
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

// Decoded AER event, valid while req is high
interface aer_event_if import ctrl_pkg::*; ();
    logic        req;
    event_kind_t kind;
    aer_addr_t   addr;
    logic        single;

    modport src (output req, output kind, output addr, output single);
    modport dst (input req, input kind, input addr, input single);
endinterface

// Current state and counters of the control FSM
interface ctrl_step_if import ctrl_pkg::*; ();
    ctrl_state_t state;
    step_t       step;
    neur_addr_t  neur_cnt;

    modport src (output state, output step, output neur_cnt);
    modport dst (input state, input step, input neur_cnt);
endinterface

`default_nettype wire

// File: logic/ctrl_pkg.sv
//----------------------------------------------------------------------
// Shared types of the event controller
// Imported by the interfaces and by every controller module
//----------------------------------------------------------------------
`default_nettype none

package ctrl_pkg;

`include "ctrl_defines.svh"

    // Vector types
    typedef logic [`CTRL_AER_W-1:0]      aer_addr_t;
    typedef logic [`CTRL_M-1:0]          neur_addr_t;
    typedef logic [`CTRL_SYN_ADDR_W-1:0] syn_addr_t;
    typedef logic [`CTRL_VIRTS_W-1:0]    virts_t;
    typedef logic [`CTRL_SCHED_W-1:0]    sched_word_t;
    typedef logic [`CTRL_PRE_EN_W-1:0]   pre_en_t;
    typedef logic [6:0]                  step_t;

    // Kind of an incoming AER event
    typedef enum logic [1:0] {
        EV_SYNAPSE,
        EV_TREF,
        EV_PUSH,
        EV_IGNORE
    } event_kind_t;

    // Control FSM states
    typedef enum logic [2:0] {
        ST_WAIT,
        ST_SYNAPSE,
        ST_TREF,
        ST_PUSH,
        ST_POP,
        ST_ACK
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: logic/event_ctrl_top.sv
//----------------------------------------------------------------------
// Event controller top level
// AER input, external scheduler and memory controls on plain ports
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defines.svh"

module event_ctrl_top import ctrl_pkg::*; (
    input  wire logic                   CLK,
    input  wire logic                   RST,
    // AER input
    input  wire logic                   aerin_req,
    input  wire aer_addr_t              aerin_addr,
    output logic                        aerin_ack,
    // Plasticity and scheduler status
    input  wire logic                   sdsp_on_syn_stim,
    input  wire logic                   sched_empty,
    input  wire logic                   sched_full,
    input  wire sched_word_t            sched_data_out,
    // Synapse array
    output syn_addr_t                   syn_addr,
    output logic                        syn_cs,
    output logic                        syn_we,
    output pre_en_t                     pre_en,
    // Neuron memory and neuron update
    output neur_addr_t                  neur_addr,
    output logic                        neur_cs,
    output logic                        neur_we,
    output logic                        neur_event,
    output logic                        neur_tref,
    output virts_t                      neur_virts,
    // Scheduler control
    output logic                        sched_pop_n,
    output neur_addr_t                  sched_addr,
    output virts_t                      sched_virts,
    output logic [`CTRL_EVENT_IN_W-1:0] sched_event_in
);

    aer_event_if ev_if ();
    ctrl_step_if st_if ();

    aer_event_decode u_decode (
        .CLK        (CLK),
        .RST        (RST),
        .aerin_req  (aerin_req),
        .aerin_addr (aerin_addr),
        .ev         (ev_if.src)
    );

    event_fsm u_fsm (
        .CLK         (CLK),
        .RST         (RST),
        .ev          (ev_if.dst),
        .sched_empty (sched_empty),
        .sched_full  (sched_full),
        .st          (st_if.src)
    );

    mem_access_gen u_strobes (
        .st               (st_if.dst),
        .ev               (ev_if.dst),
        .sdsp_on_syn_stim (sdsp_on_syn_stim),
        .sched_data_out   (sched_data_out),
        .syn_addr         (syn_addr),
        .syn_cs           (syn_cs),
        .syn_we           (syn_we),
        .pre_en           (pre_en),
        .neur_addr        (neur_addr),
        .neur_cs          (neur_cs),
        .neur_we          (neur_we),
        .neur_event       (neur_event),
        .neur_tref        (neur_tref),
        .neur_virts       (neur_virts),
        .sched_pop_n      (sched_pop_n),
        .sched_addr       (sched_addr),
        .sched_virts      (sched_virts),
        .sched_event_in   (sched_event_in),
        .aerin_ack        (aerin_ack)
    );

endmodule

`default_nettype wire

// File: logic/event_fsm.sv
//----------------------------------------------------------------------
// Control FSM of the event controller
// Picks the next job from AER and scheduler, and keeps the step counter
// and the neuron counter that the strobe decoder works from
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defines.svh"

module event_fsm import ctrl_pkg::*; (
    input  wire logic CLK,
    input  wire logic RST,
    aer_event_if.dst  ev,
    input  wire logic sched_empty,
    input  wire logic sched_full,
    ctrl_step_if.src  st
);

    localparam step_t LAST_PAIR_STEP  = step_t'(1);
    localparam step_t LAST_BLOCK_STEP = step_t'(2*`CTRL_TREF_BLOCK-1);

    ctrl_state_t state;
    ctrl_state_t next_state;
    step_t       step;
    neur_addr_t  neur_cnt;
    logic        tref_done;

    // A block tref walks 32 neurons with a read and a write each
    assign tref_done = ev.single ? (step == LAST_PAIR_STEP) : (step == LAST_BLOCK_STEP);

    // ------------------------------------------------------------------
    // State register
    // ------------------------------------------------------------------
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            state <= ST_WAIT;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            ST_WAIT: begin
                // A full scheduler is drained before any new AER event
                if (sched_full) begin
                    next_state = ST_POP;
                end else if (ev.req && ev.kind == EV_SYNAPSE) begin
                    next_state = ST_SYNAPSE;
                end else if (ev.req && ev.kind == EV_TREF) begin
                    next_state = ST_TREF;
                end else if (ev.req && ev.kind == EV_PUSH) begin
                    next_state = ST_PUSH;
                end else if (ev.req && ev.kind == EV_IGNORE) begin
                    next_state = ST_ACK;
                end else if (!sched_empty) begin
                    next_state = ST_POP;
                end
            end
            ST_SYNAPSE: begin
                if (step == LAST_PAIR_STEP) begin
                    next_state = ST_ACK;
                end
            end
            ST_TREF: begin
                if (tref_done) begin
                    next_state = ST_ACK;
                end
            end
            ST_PUSH: begin
                next_state = ST_ACK;
            end
            ST_POP: begin
                // Scheduler pops are internal, no handshake to close
                if (step == LAST_PAIR_STEP) begin
                    next_state = ST_WAIT;
                end
            end
            ST_ACK: begin
                if (!ev.req) begin
                    next_state = ST_WAIT;
                end
            end
            default: begin
                next_state = ST_WAIT;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // Step and neuron counters
    // ------------------------------------------------------------------
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            step     <= '0;
            neur_cnt <= '0;
        end else if (state == ST_WAIT) begin
            step     <= '0;
            neur_cnt <= '0;
        end else begin
            step <= step + step_t'(1);
            // Next neuron once the current one has been written back
            if (state == ST_TREF && !ev.single && step[0]) begin
                neur_cnt <= neur_cnt + neur_addr_t'(1);
            end
        end
    end

    assign st.state    = state;
    assign st.step     = step;
    assign st.neur_cnt = neur_cnt;

endmodule

`default_nettype wire

// File: logic/mem_access_gen.sv
//----------------------------------------------------------------------
// Strobe decoder of the event controller
// Turns FSM state and step into memory, neuron and scheduler controls
// Even steps read, odd steps write
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defines.svh"

module mem_access_gen import ctrl_pkg::*; (
    ctrl_step_if.dst                    st,
    aer_event_if.dst                    ev,
    input  wire logic                   sdsp_on_syn_stim,
    input  wire sched_word_t            sched_data_out,
    // Synapse array
    output syn_addr_t                   syn_addr,
    output logic                        syn_cs,
    output logic                        syn_we,
    output pre_en_t                     pre_en,
    // Neuron memory and neuron update
    output neur_addr_t                  neur_addr,
    output logic                        neur_cs,
    output logic                        neur_we,
    output logic                        neur_event,
    output logic                        neur_tref,
    output virts_t                      neur_virts,
    // Scheduler
    output logic                        sched_pop_n,
    output neur_addr_t                  sched_addr,
    output virts_t                      sched_virts,
    output logic [`CTRL_EVENT_IN_W-1:0] sched_event_in,
    // AER return
    output logic                        aerin_ack
);

    logic wr_phase;

    assign wr_phase = st.step[0];

    always_comb begin
        syn_addr       = '0;
        syn_cs         = 1'b0;
        syn_we         = 1'b0;
        pre_en         = '0;
        neur_addr      = '0;
        neur_cs        = 1'b0;
        neur_we        = 1'b0;
        neur_event     = 1'b0;
        neur_tref      = 1'b0;
        neur_virts     = '0;
        sched_pop_n    = 1'b1;
        sched_addr     = '0;
        sched_virts    = '0;
        sched_event_in = '0;
        aerin_ack      = 1'b0;

        case (st.state)
            ST_SYNAPSE: begin
                // Read-modify-write of one synapse word and the target neuron
                syn_addr   = ev.addr[2*`CTRL_M-1:`CTRL_PRE_SEL_W];
                neur_addr  = ev.addr[`CTRL_M-1:0];
                syn_cs     = 1'b1;
                neur_cs    = 1'b1;
                syn_we     = wr_phase;
                neur_we    = wr_phase;
                neur_event = 1'b1;
                pre_en     = pre_en_t'(sdsp_on_syn_stim) << ev.addr[`CTRL_PRE_SEL_W-1:0];
            end
            ST_TREF: begin
                neur_addr  = ev.single ? ev.addr[2*`CTRL_M-1:`CTRL_M] : st.neur_cnt;
                neur_cs    = 1'b1;
                neur_we    = wr_phase;
                neur_event = 1'b1;
                neur_tref  = 1'b1;
            end
            ST_PUSH: begin
                sched_addr     = ev.addr[2*`CTRL_M-1:`CTRL_M];
                sched_virts    = ev.addr[`CTRL_M-1:`CTRL_PRE_SEL_W];
                sched_event_in = `CTRL_PUSH_CODE;
            end
            ST_POP: begin
                // Head entry goes to its neuron, popped with the write
                neur_addr   = sched_data_out[`CTRL_M-1:0];
                neur_virts  = sched_data_out[`CTRL_SCHED_W-1:`CTRL_M];
                neur_cs     = 1'b1;
                neur_event  = 1'b1;
                neur_we     = wr_phase;
                sched_pop_n = ~wr_phase;
            end
            ST_ACK: begin
                aerin_ack = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the event controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module event_ctrl_tb -f build.f -Mdir obj_dir -o event_ctrl_sim
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/event_ctrl_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
    exit 0
fi
echo "Simulation reported failures"
exit 1

// File: tests/event_ctrl_model.svh
//----------------------------------------------------------------------
// Reference model of the event controller write sequence
// Included into the testbench body, appends predicted writes to exp_q
//----------------------------------------------------------------------
`ifndef EVENT_CTRL_MODEL_SVH
`define EVENT_CTRL_MODEL_SVH

// Tags of a predicted write word
localparam logic [1:0] TAG_SYN  = 2'd0;
localparam logic [1:0] TAG_TREF = 2'd1;
localparam logic [1:0] TAG_PUSH = 2'd2;

// Layout: tag, synapse address, neuron address, pre-enable, virts
function automatic logic [35:0] pack_write(input logic [1:0] tag, input logic [12:0] saddr,
                                           input logic [7:0] naddr, input logic [7:0] pen,
                                           input logic [4:0] virts);
    return {tag, saddr, naddr, pen, virts};
endfunction

// Classifies one AER address and queues the writes it must produce
task automatic predict_event(input logic [16:0] addr, input logic sdsp, output logic ignore);
    logic [7:0] pen;
    logic [6:0] low7;
    int         n;
    low7   = addr[6:0];
    pen    = '0;
    ignore = 1'b0;
    // One-hot plasticity enable at the position given by the low 3 bits
    pen[addr[2:0]] = sdsp;
    if (addr[16]) begin
        exp_q.push_back(pack_write(TAG_SYN, addr[15:3], addr[7:0], pen, 5'd0));
    end else if (low7 == 7'h7f && addr[7]) begin
        exp_q.push_back(pack_write(TAG_TREF, 13'd0, addr[15:8], 8'd0, 5'd0));
    end else if (low7 == 7'h7f) begin
        for (n = 0; n < `CTRL_TREF_BLOCK; n++) begin
            exp_q.push_back(pack_write(TAG_TREF, 13'd0, 8'(n), 8'd0, 5'd0));
        end
    end else if (low7 != 7'h00) begin
        exp_q.push_back(pack_write(TAG_PUSH, 13'd0, addr[15:8], 8'd0, addr[7:3]));
    end else begin
        ignore = 1'b1;
    end
endtask

`endif

// File: tests/event_ctrl_tb.sv
//----------------------------------------------------------------------
// Testbench of the event controller
// Random AER events over the four-phase handshake, a 4-deep scheduler
// emulation, and every write strobe checked against the model
//----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "ctrl_defines.svh"

module event_ctrl_tb;

    localparam int NUM_EVENTS     = 60;
    localparam int SCHED_DEPTH    = 4;
    localparam int TIMEOUT_CYCLES = NUM_EVENTS * 80 + 1000;

    logic        CLK = 1'b0;
    logic        RST;
    logic        aerin_req;
    logic [16:0] aerin_addr;
    logic        aerin_ack;
    logic        sdsp_on_syn_stim;
    logic        sched_empty;
    logic        sched_full;
    logic [12:0] sched_data_out;
    logic [12:0] syn_addr;
    logic        syn_cs;
    logic        syn_we;
    logic [7:0]  pre_en;
    logic [7:0]  neur_addr;
    logic        neur_cs;
    logic        neur_we;
    logic        neur_event;
    logic        neur_tref;
    logic [4:0]  neur_virts;
    logic        sched_pop_n;
    logic [7:0]  sched_addr;
    logic [4:0]  sched_virts;
    logic [6:0]  sched_event_in;

    logic [35:0] exp_q[$];
    logic [12:0] sched_q[$];
    logic [12:0] preload_q[$];
    logic        pend_pop = 1'b0;
    logic        pend_push = 1'b0;
    logic [12:0] push_word;
    logic [31:0] rng = 32'd5291;
    int          errors = 0;
    int          checks = 0;
    int          aer_strobes = 0;
    int          i;
    int          gap;

    `include "event_ctrl_model.svh"

    event_ctrl_top UUT (.*);

    always #2 CLK = ~CLK;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Event mix: 3/8 synapse, single and block tref, push, ignore
    function automatic logic [16:0] make_addr(input logic [31:0] r);
        logic [6:0] low7;
        low7 = r[18:12];
        if (low7 == 7'h00 || low7 == 7'h7f) begin
            low7 = 7'h15;
        end
        case (r[2:0])
            3'd0, 3'd1, 3'd2: return {1'b1, r[26:11]};
            3'd3:    return {1'b0, r[10:3], 1'b1, 7'h7f};
            3'd4:    return {1'b0, r[10:3], 1'b0, 7'h7f};
            3'd7:    return {1'b0, r[10:3], r[11], 7'h00};
            default: return {1'b0, r[10:3], r[11], low7};
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic check_idle();
        check_val("syn_cs", 32'd0, 32'(syn_cs));
        check_val("syn_we", 32'd0, 32'(syn_we));
        check_val("neur_cs", 32'd0, 32'(neur_cs));
        check_val("neur_we", 32'd0, 32'(neur_we));
        check_val("neur_event", 32'd0, 32'(neur_event));
        check_val("neur_tref", 32'd0, 32'(neur_tref));
        check_val("aerin_ack", 32'd0, 32'(aerin_ack));
        check_val("sched_pop_n", 32'd1, 32'(sched_pop_n));
        check_val("sched_event_in", 32'd0, 32'(sched_event_in));
        check_val("pre_en", 32'd0, 32'(pre_en));
        check_val("syn_addr", 32'd0, 32'(syn_addr));
        check_val("neur_addr", 32'd0, 32'(neur_addr));
        check_val("sched_addr", 32'd0, 32'(sched_addr));
        check_val("neur_virts", 32'd0, 32'(neur_virts));
        check_val("sched_virts", 32'd0, 32'(sched_virts));
    endtask

    task automatic check_write(input logic [35:0] w);
        case (w[35:34])
            TAG_SYN: begin
                check_val("syn_cs", 32'd1, 32'(syn_cs));
                check_val("neur_cs", 32'd1, 32'(neur_cs));
                check_val("neur_event", 32'd1, 32'(neur_event));
                check_val("syn_we", 32'd1, 32'(syn_we));
                check_val("neur_we", 32'd1, 32'(neur_we));
                check_val("syn_addr", 32'(w[33:21]), 32'(syn_addr));
                check_val("neur_addr", 32'(w[20:13]), 32'(neur_addr));
                check_val("pre_en", 32'(w[12:5]), 32'(pre_en));
            end
            TAG_TREF: begin
                check_val("neur_cs", 32'd1, 32'(neur_cs));
                check_val("neur_event", 32'd1, 32'(neur_event));
                check_val("neur_we", 32'd1, 32'(neur_we));
                check_val("neur_tref", 32'd1, 32'(neur_tref));
                check_val("neur_addr", 32'(w[20:13]), 32'(neur_addr));
            end
            default: begin
                check_val("sched_event_in", 32'h40, 32'(sched_event_in));
                check_val("sched_addr", 32'(w[20:13]), 32'(sched_addr));
                check_val("sched_virts", 32'(w[4:0]), 32'(sched_virts));
                if (sched_q.size() >= SCHED_DEPTH) begin
                    report_failure("push into a full scheduler");
                end
                pend_push = 1'b1;
                push_word = {w[4:0], w[20:13]};
            end
        endcase
    endtask

    // Four-phase handshake, address held until ack falls
    task automatic send_event(input logic [16:0] addr, input logic sdsp);
        logic ignore;
        @(posedge CLK);
        aerin_addr       <= addr;
        sdsp_on_syn_stim <= sdsp;
        aerin_req        <= 1'b1;
        predict_event(addr, sdsp, ignore);
        aer_strobes = 0;
        @(negedge CLK);
        while (!aerin_ack) @(negedge CLK);
        if (exp_q.size() != 0) begin
            report_failure("acknowledge came before all predicted writes");
        end
        if (ignore && aer_strobes != 0) begin
            report_failure("memory strobe on an ignored address");
        end
        @(posedge CLK);
        aerin_req <= 1'b0;
        @(negedge CLK);
        while (aerin_ack) @(negedge CLK);
    endtask

    // ------------------------------------------------------------------
    // Monitor, samples mid-cycle where the decoded strobes are stable
    // ------------------------------------------------------------------
    always @(negedge CLK) begin : monitor
        logic [35:0] w;
        if (!RST) begin
            if (!sched_pop_n) begin
                if (sched_q.size() == 0) begin
                    report_failure("pop from an empty scheduler");
                end else begin
                    check_val("neur_we", 32'd1, 32'(neur_we));
                    check_val("neur_addr", 32'(sched_q[0][7:0]), 32'(neur_addr));
                    check_val("neur_virts", 32'(sched_q[0][12:8]), 32'(neur_virts));
                end
                pend_pop = 1'b1;
            end else if (syn_we || neur_we || sched_event_in != 7'd0) begin
                if (sched_full) begin
                    report_failure("AER write while the scheduler is full");
                end
                if (exp_q.size() == 0) begin
                    report_failure("write strobe with no predicted write");
                end else begin
                    w = exp_q.pop_front();
                    check_write(w);
                end
            end
            if (syn_cs || neur_tref || sched_event_in != 7'd0) begin
                aer_strobes++;
            end
        end
    end

    // ------------------------------------------------------------------
    // Scheduler emulation
    // ------------------------------------------------------------------
    always @(posedge CLK) begin
        if (pend_pop && sched_q.size() > 0) begin
            sched_q.delete(0);
        end
        if (pend_push) begin
            sched_q.push_back(push_word);
        end
        pend_pop  = 1'b0;
        pend_push = 1'b0;
        while (preload_q.size() > 0) begin
            sched_q.push_back(preload_q.pop_front());
        end
        sched_empty    <= (sched_q.size() == 0);
        sched_full     <= (sched_q.size() >= SCHED_DEPTH);
        sched_data_out <= (sched_q.size() > 0) ? sched_q[0] : 13'd0;
    end

    initial begin
        RST              = 1'b1;
        aerin_req        = 1'b0;
        aerin_addr       = '0;
        sdsp_on_syn_stim = 1'b0;
        sched_empty      = 1'b1;
        sched_full       = 1'b0;
        sched_data_out   = '0;
        repeat (5) @(posedge CLK);
        RST <= 1'b0;
        repeat (2) @(negedge CLK);
        check_idle();

        // Full scheduler lands together with a synapse request
        rng = xorshift32(rng);
        fork
            send_event({1'b1, rng[28:13]}, 1'b1);
            begin
                // Queue fills in the cycle the request leaves the synchronizer
                repeat (2) @(posedge CLK);
                @(negedge CLK);
                for (i = 0; i < SCHED_DEPTH; i++) begin
                    rng = xorshift32(rng);
                    preload_q.push_back(rng[12:0]);
                end
            end
        join

        for (i = 0; i < NUM_EVENTS; i++) begin
            rng = xorshift32(rng);
            gap = int'(rng[31:30]);
            repeat (gap) @(posedge CLK);
            send_event(make_addr(rng), rng[29]);
        end

        while (sched_q.size() != 0) @(negedge CLK);
        repeat (4) @(negedge CLK);
        if (exp_q.size() != 0) begin
            report_failure("predicted writes were never seen");
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        $display("Timeout: run still busy after %0d cycles, errors: %0d", TIMEOUT_CYCLES, errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
